//--- dram_scrub_top.f
source/scrub_pkg.sv
source/reset_and_flr.sv
source/scrub_ctl_decode.sv
source/mem_scrubber.sv
source/scrub_status_mux.sv
source/dram_scrub_top.sv
verification/tb_clock_gen.sv
verification/dram_scrub_tb.sv

//--- source/dram_scrub_top.sv
/*
 * Top level of the four-channel scrub controller.
 * Reset and FLR logic, the control decoder, one scrubber per memory
 * channel and the status mux. Each channel talks to its memory through a
 * four-phase mem_req/mem_ack handshake carrying the burst address.
 */

`timescale 1ns/1ns

module dram_scrub_top
(
   input  logic                          clk,
   input  logic                          rst_main_n,
   input  logic                          flr_assert,
   input  logic [scrub_pkg::WORD_W-1:0]  ctl_word,
   input  logic [scrub_pkg::NUM_CH-1:0]  ddr_is_ready,
   input  logic [scrub_pkg::NUM_CH-1:0]  mem_ack,
   output logic                          flr_done,
   output logic [scrub_pkg::WORD_W-1:0]  status_word,
   output logic [scrub_pkg::WORD_W-1:0]  id0,
   output logic [scrub_pkg::WORD_W-1:0]  id1,
   output logic [scrub_pkg::NUM_CH-1:0]  mem_req,
   output logic [scrub_pkg::ADDR_W-1:0]  mem_addr [scrub_pkg::NUM_CH]
);

   logic                                                 sync_rst_n;
   logic [scrub_pkg::NUM_CH-1:0]                         scrub_en;
   logic                                                 dbg_en;
   logic [2:0]                                           dbg_sel;
   logic [scrub_pkg::NUM_CH-1:0]                         ready_q;
   logic [scrub_pkg::NUM_CH-1:0]                         scrub_done;
   logic [scrub_pkg::NUM_CH-1:0][scrub_pkg::STATE_W-1:0] scrub_state;

   // ------------------------------
   // Reset and control
   // ------------------------------
   reset_and_flr u_reset_and_flr
   (
      .clk        (clk),
      .rst_main_n (rst_main_n),
      .flr_assert (flr_assert),
      .sync_rst_n (sync_rst_n),
      .flr_done   (flr_done)
   );

   scrub_ctl_decode u_ctl_decode
   (
      .clk          (clk),
      .sync_rst_n   (sync_rst_n),
      .ctl_word     (ctl_word),
      .ddr_is_ready (ddr_is_ready),
      .scrub_en     (scrub_en),
      .dbg_en       (dbg_en),
      .dbg_sel      (dbg_sel),
      .ready_q      (ready_q)
   );

   // ------------------------------
   // One scrubber per channel
   // ------------------------------
   for (genvar ch = 0; ch < scrub_pkg::NUM_CH; ch++)
   begin : g_scrub
      mem_scrubber u_scrubber
      (
         .clk        (clk),
         .sync_rst_n (sync_rst_n),
         .enable     (scrub_en[ch]),
         .mem_ack    (mem_ack[ch]),
         .mem_req    (mem_req[ch]),
         .mem_addr   (mem_addr[ch]),
         .state      (scrub_state[ch]),
         .done       (scrub_done[ch])
      );
   end

   // Scrub addresses are read straight off the memory address ports
   scrub_status_mux u_status_mux
   (
      .clk         (clk),
      .dbg_en      (dbg_en),
      .dbg_sel     (dbg_sel),
      .ready_q     (ready_q),
      .scrub_done  (scrub_done),
      .scrub_state (scrub_state),
      .scrub_addr  (mem_addr),
      .status_word (status_word),
      .id0         (id0),
      .id1         (id1)
   );

endmodule

//--- source/mem_scrubber.sv
/*
 * Burst address walker for one memory channel.
 * While enabled it requests every burst of the scrub range in order with a
 * four-phase req/ack handshake, then parks in the done state until the
 * enable is cleared. The current address is also read by the status mux.
 */

`timescale 1ns/1ns

module mem_scrubber
(
   input  logic                            clk,
   input  logic                            sync_rst_n,
   input  logic                            enable,
   input  logic                            mem_ack,
   output logic                            mem_req,
   output logic [scrub_pkg::ADDR_W-1:0]    mem_addr,
   output logic [scrub_pkg::STATE_W-1:0]   state,
   output logic                            done
);

   logic at_last_burst;

   // Start address of the final burst in the range
   assign at_last_burst = (mem_addr == (scrub_pkg::SCRUB_LAST_ADDR + 64'd1
                                        - scrub_pkg::BURST_STEP));

   // ------------------------------
   // Handshake FSM
   // ------------------------------
   always_ff @(posedge clk or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
      begin
         state    <= scrub_pkg::ST_IDLE;
         mem_addr <= '0;
      end
      else
      begin
         case (state)
            scrub_pkg::ST_IDLE:
            begin
               mem_addr <= '0;
               if (enable)
               begin
                  state <= scrub_pkg::ST_REQ;
               end
            end

            // Request stays up until the responder answers
            scrub_pkg::ST_REQ:
            begin
               if (mem_ack)
               begin
                  state <= scrub_pkg::ST_RELEASE;
               end
            end

            // Wait for ack to drop before touching the address
            scrub_pkg::ST_RELEASE:
            begin
               if (!mem_ack)
               begin
                  if (!enable)
                  begin
                     state    <= scrub_pkg::ST_IDLE;
                     mem_addr <= '0;
                  end
                  else if (at_last_burst)
                  begin
                     state <= scrub_pkg::ST_DONE;
                  end
                  else
                  begin
                     state    <= scrub_pkg::ST_REQ;
                     mem_addr <= mem_addr + scrub_pkg::BURST_STEP;
                  end
               end
            end

            // Last address is kept visible until disabled
            scrub_pkg::ST_DONE:
            begin
               if (!enable)
               begin
                  state    <= scrub_pkg::ST_IDLE;
                  mem_addr <= '0;
               end
            end

            default:
            begin
               state    <= scrub_pkg::ST_IDLE;
               mem_addr <= '0;
            end
         endcase
      end
   end

   assign mem_req = (state == scrub_pkg::ST_REQ);
   assign done    = (state == scrub_pkg::ST_DONE);

endmodule

//--- source/reset_and_flr.sv
/*
 * Reset synchronizer and function-level-reset response.
 * The raw reset runs through a short unreset pipe, then two flops with an
 * asynchronous clear produce sync_rst_n for the rest of the design.
 * An FLR request is registered and answered with a completion pulse.
 */

`timescale 1ns/1ns

module reset_and_flr
(
   input  logic clk,
   input  logic rst_main_n,
   input  logic flr_assert,
   output logic sync_rst_n,
   output logic flr_done
);

   logic [scrub_pkg::RST_PIPE_STAGES-1:0] rst_pipe;
   logic                                  pipe_rst_n;
   logic                                  pre_sync_rst_n;
   logic                                  flr_assert_q;

   // ------------------------------
   // Reset synchronizer
   // ------------------------------
   always_ff @(posedge clk)
   begin
      rst_pipe <= {rst_pipe[scrub_pkg::RST_PIPE_STAGES-2:0], rst_main_n};
   end

   assign pipe_rst_n = rst_pipe[scrub_pkg::RST_PIPE_STAGES-1];

   // Assert at once, release two clocks after the pipe output rises
   always_ff @(posedge clk or negedge pipe_rst_n)
   begin
      if (!pipe_rst_n)
      begin
         pre_sync_rst_n <= 1'b0;
         sync_rst_n     <= 1'b0;
      end
      else
      begin
         pre_sync_rst_n <= 1'b1;
         sync_rst_n     <= pre_sync_rst_n;
      end
   end

   // ------------------------------
   // FLR response
   // ------------------------------
   // A held request toggles done, so it pulses every other cycle
   always_ff @(posedge clk or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
      begin
         flr_assert_q <= 1'b0;
         flr_done     <= 1'b0;
      end
      else
      begin
         flr_assert_q <= flr_assert;
         flr_done     <= flr_assert_q && !flr_done;
      end
   end

endmodule

//--- source/scrub_ctl_decode.sv
/*
 * Control word register and decode.
 * Captures the control word and the memory ready flags once, then hands
 * the per-channel scrub enables to the scrubbers and the debug enable and
 * channel select to the status mux.
 */

`timescale 1ns/1ns

module scrub_ctl_decode
(
   input  logic                           clk,
   input  logic                           sync_rst_n,
   input  logic [scrub_pkg::WORD_W-1:0]   ctl_word,
   input  logic [scrub_pkg::NUM_CH-1:0]   ddr_is_ready,
   output logic [scrub_pkg::NUM_CH-1:0]   scrub_en,
   output logic                           dbg_en,
   output logic [2:0]                     dbg_sel,
   output logic [scrub_pkg::NUM_CH-1:0]   ready_q
);

   // Only the decoded fields are kept, the other control bits are reserved
   always_ff @(posedge clk or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
      begin
         scrub_en <= '0;
         dbg_en   <= 1'b0;
         dbg_sel  <= '0;
         ready_q  <= '0;
      end
      else
      begin
         // Bit n enables channel n
         scrub_en <= ctl_word[scrub_pkg::NUM_CH-1:0];
         dbg_en   <= ctl_word[scrub_pkg::CTL_DBG_EN_BIT];
         dbg_sel  <= ctl_word[scrub_pkg::CTL_DBG_SEL_HI:scrub_pkg::CTL_DBG_SEL_LO];
         ready_q  <= ddr_is_ready;
      end
   end

endmodule

//--- source/scrub_pkg.sv
/*
 * Shared constants and the status word layout for the four-channel
 * memory scrub controller. All design files and the testbench refer to
 * these definitions with scoped names.
 */

package scrub_pkg;

   // ------------------------------
   // Sizes
   // ------------------------------
   localparam int NUM_CH          = 4;
   localparam int ADDR_W          = 64;
   localparam int WORD_W          = 32;
   localparam int STATE_W         = 3;
   localparam int RST_PIPE_STAGES = 4;

   // Simulation-sized scrub range of 64 bursts per pass
   localparam logic [ADDR_W-1:0] BURST_STEP      = 64'd16;
   localparam logic [ADDR_W-1:0] SCRUB_LAST_ADDR = 64'h3FF;

   // Scrubber FSM encodings
   localparam logic [STATE_W-1:0] ST_IDLE    = 3'd0;
   localparam logic [STATE_W-1:0] ST_REQ     = 3'd1;
   localparam logic [STATE_W-1:0] ST_RELEASE = 3'd2;
   localparam logic [STATE_W-1:0] ST_DONE    = 3'd3;

   // Debug fields of the control word, above the enables in bits NUM_CH-1..0
   localparam int CTL_DBG_EN_BIT = 31;
   localparam int CTL_DBG_SEL_HI = 30;
   localparam int CTL_DBG_SEL_LO = 28;

   // Fixed identification and status constants
   localparam logic [19:0]       STATUS_SIGNATURE = 20'hA1111;
   localparam logic [3:0]        STATUS_MARK      = 4'hF;
   localparam logic [WORD_W-1:0] ID0_VALUE        = 32'h1D50_6789;
   localparam logic [WORD_W-1:0] ID1_VALUE        = 32'h1D51_FEDC;

   // Status word read either as the normal or the debug layout
   typedef union packed {
      struct packed {
         logic [19:0]       signature;
         logic [3:0]        mark;
         logic [NUM_CH-1:0] done;
         logic [NUM_CH-1:0] ready;
      } normal;
      struct packed {
         logic [NUM_CH-1:0][STATE_W:0] ch_field;
         logic [3:0]                   pad;
         logic [3:0]                   mark;
         logic [NUM_CH-1:0]            done;
         logic [NUM_CH-1:0]            ready;
      } debug;
   } status_word_u;

endpackage

//--- source/scrub_status_mux.sv
/*
 * Status and identification word mux.
 * Builds the status word in its normal or debug layout from all scrubbers
 * and picks either the fixed IDs or the selected channel's scrub address
 * for the two ID words. All three outputs are registered.
 */

`timescale 1ns/1ns

module scrub_status_mux
(
   input  logic                                                 clk,
   input  logic                                                 dbg_en,
   input  logic [2:0]                                           dbg_sel,
   input  logic [scrub_pkg::NUM_CH-1:0]                         ready_q,
   input  logic [scrub_pkg::NUM_CH-1:0]                         scrub_done,
   input  logic [scrub_pkg::NUM_CH-1:0][scrub_pkg::STATE_W-1:0] scrub_state,
   input  logic [scrub_pkg::ADDR_W-1:0]                         scrub_addr [scrub_pkg::NUM_CH],
   output logic [scrub_pkg::WORD_W-1:0]                         status_word,
   output logic [scrub_pkg::WORD_W-1:0]                         id0,
   output logic [scrub_pkg::WORD_W-1:0]                         id1
);

   scrub_pkg::status_word_u                   status_next;
   logic [$clog2(scrub_pkg::NUM_CH)-1:0]      sel_ch;

   // ------------------------------
   // Status word
   // ------------------------------
   always_comb
   begin
      status_next = '0;
      if (dbg_en)
      begin
         // Channel 3 lands in the top nibble
         for (int ch = 0; ch < scrub_pkg::NUM_CH; ch++)
         begin
            status_next.debug.ch_field[ch] = {1'b0, scrub_state[ch]};
         end
         status_next.debug.pad   = 4'h0;
         status_next.debug.mark  = scrub_pkg::STATUS_MARK;
         status_next.debug.done  = scrub_done;
         status_next.debug.ready = ready_q;
      end
      else
      begin
         status_next.normal.signature = scrub_pkg::STATUS_SIGNATURE;
         status_next.normal.mark      = scrub_pkg::STATUS_MARK;
         status_next.normal.done      = scrub_done;
         status_next.normal.ready     = ready_q;
      end
   end

   // Selects beyond the last channel fall back to channel 0
   assign sel_ch = (dbg_sel < scrub_pkg::NUM_CH) ?
                   dbg_sel[$clog2(scrub_pkg::NUM_CH)-1:0] : '0;

   // ------------------------------
   // Output registers
   // ------------------------------
   always_ff @(posedge clk)
   begin
      status_word <= status_next;
      if (dbg_en)
      begin
         id0 <= scrub_addr[sel_ch][scrub_pkg::WORD_W-1:0];
         id1 <= scrub_addr[sel_ch][scrub_pkg::ADDR_W-1:scrub_pkg::WORD_W];
      end
      else
      begin
         id0 <= scrub_pkg::ID0_VALUE;
         id1 <= scrub_pkg::ID1_VALUE;
      end
   end

endmodule

//--- verification/dram_scrub_tb.sv
/*
 * Testbench for the four-channel scrub controller.
 * Random channel subsets are scrubbed against one memory responder per
 * channel, the handshake and burst addresses are watched, the status and ID
 * words are compared in both layouts and the FLR pulse is checked.
 */

`timescale 1ns/1ns

module dram_scrub_tb;

   localparam int CLK_PERIOD    = 40;
   localparam int RESET_LATENCY = 6;
   localparam int NUM_ROUNDS    = 6;
   localparam int BURSTS = int'((scrub_pkg::SCRUB_LAST_ADDR + 64'd1) / scrub_pkg::BURST_STEP);
   localparam logic [63:0] LAST_BURST = 64'(BURSTS - 1) * scrub_pkg::BURST_STEP;
   // Worst case about ten cycles per burst, with some slack on top
   localparam int WATCHDOG_NS =
      NUM_ROUNDS * scrub_pkg::NUM_CH * BURSTS * 10 * CLK_PERIOD + 20000;

   logic                                clk;
   logic                                rst_main_n;
   logic                                flr_assert;
   logic [scrub_pkg::WORD_W-1:0]        ctl_word;
   logic [scrub_pkg::NUM_CH-1:0]        ddr_is_ready;
   logic [scrub_pkg::NUM_CH-1:0]        mem_ack;
   logic                                flr_done;
   logic [scrub_pkg::WORD_W-1:0]        status_word;
   logic [scrub_pkg::WORD_W-1:0]        id0;
   logic [scrub_pkg::WORD_W-1:0]        id1;
   logic [scrub_pkg::NUM_CH-1:0]        mem_req;
   logic [scrub_pkg::ADDR_W-1:0]        mem_addr [scrub_pkg::NUM_CH];

   int                                  error_count;
   int                                  burst_count [scrub_pkg::NUM_CH];
   logic [scrub_pkg::NUM_CH-1:0]        model_en;
   logic                                ready_check_on;

   tb_clock_gen u_clock_gen (.clk(clk));

   dram_scrub_top UUT
   (
      .clk          (clk),
      .rst_main_n   (rst_main_n),
      .flr_assert   (flr_assert),
      .ctl_word     (ctl_word),
      .ddr_is_ready (ddr_is_ready),
      .mem_ack      (mem_ack),
      .flr_done     (flr_done),
      .status_word  (status_word),
      .id0          (id0),
      .id1          (id1),
      .mem_req      (mem_req),
      .mem_addr     (mem_addr)
   );

   // ------------------------------
   // Reporting
   // ------------------------------
   task automatic check_value(input string name, input logic [63:0] actual,
                              input logic [63:0] expected);
      if (actual !== expected)
      begin
         error_count++;
         $display("CHECK FAILED at %0t ns: %s is %0h, expected %0h",
                  $time, name, actual, expected);
      end
   endtask

   task automatic report_error(input string msg);
      error_count++;
      $display("Error at %0t ns: %s", $time, msg);
   endtask

   // ------------------------------
   // Memory side
   // ------------------------------
   // Four-phase responder with 0 to 3 cycles of delay on each edge of ack
   task automatic respond_channel(input int ch);
      int delay;
      forever
      begin
         @(negedge clk);
         if (mem_req[ch] != mem_ack[ch])
         begin
            delay = $urandom_range(3, 0);
            repeat (delay) @(posedge clk);
            @(posedge clk);
            mem_ack[ch] <= mem_req[ch];
         end
      end
   endtask

   // Burst order, address hold and request rules of one channel
   task automatic watch_channel(input int ch);
      logic                         prev_req;
      logic                         in_xfer;
      logic [scrub_pkg::ADDR_W-1:0] held_addr;
      prev_req = 1'b0;
      in_xfer  = 1'b0;
      forever
      begin
         @(negedge clk);
         if (mem_req[ch] && !prev_req)
         begin
            if (mem_ack[ch])
               report_error($sformatf("channel %0d raised mem_req while mem_ack high", ch));
            if (!model_en[ch])
               report_error($sformatf("disabled channel %0d raised mem_req", ch));
            if (burst_count[ch] >= BURSTS)
               report_error($sformatf("channel %0d requested past the scrub range", ch));
            check_value($sformatf("mem_addr[%0d]", ch), mem_addr[ch],
                        64'(burst_count[ch]) * scrub_pkg::BURST_STEP);
            burst_count[ch]++;
            held_addr = mem_addr[ch];
            in_xfer   = 1'b1;
         end
         else if (in_xfer)
         begin
            if (mem_addr[ch] !== held_addr)
               report_error($sformatf("channel %0d changed mem_addr during a handshake", ch));
            in_xfer = mem_req[ch] || mem_ack[ch];
         end
         prev_req = mem_req[ch];
      end
   endtask

   // Ready flags change every cycle and show in the status two cycles later
   task automatic drive_ready_flags();
      forever
      begin
         @(posedge clk);
         ddr_is_ready <= 4'($urandom_range(15, 0));
      end
   endtask

   task automatic watch_ready();
      logic [scrub_pkg::NUM_CH-1:0] ready_d1;
      logic [scrub_pkg::NUM_CH-1:0] ready_d2;
      ready_d1 = '0;
      ready_d2 = '0;
      forever
      begin
         @(negedge clk);
         if (ready_check_on)
            check_value("status_word.ready", status_word[3:0], ready_d2);
         ready_d2 = ready_d1;
         ready_d1 = ddr_is_ready;
      end
   endtask

   // ------------------------------
   // Stimulus and expected words
   // ------------------------------
   task automatic drive_ctl(input logic dbg, input logic [2:0] sel, input logic [3:0] en);
      @(posedge clk);
      ctl_word <= {dbg, sel, 24'($urandom), en};
      model_en  = en;
   endtask

   // A control change reaches the outputs two cycles later
   task automatic wait_outputs();
      repeat (2) @(posedge clk);
      @(negedge clk);
   endtask

   task automatic check_normal(input logic [3:0] en);
      scrub_pkg::status_word_u exp;
      exp                  = '0;
      exp.normal.signature = scrub_pkg::STATUS_SIGNATURE;
      exp.normal.mark      = scrub_pkg::STATUS_MARK;
      exp.normal.done      = en;
      check_value("status_word[31:4]", status_word[31:4], exp[31:4]);
      check_value("id0", id0, scrub_pkg::ID0_VALUE);
      check_value("id1", id1, scrub_pkg::ID1_VALUE);
   endtask

   // Enabled channels sit in done at the last burst and the rest idle at 0
   task automatic check_debug(input logic [3:0] en, input logic [2:0] sel);
      scrub_pkg::status_word_u exp;
      int                      sel_ch;
      logic [63:0]             addr;
      exp = '0;
      for (int ch = 0; ch < scrub_pkg::NUM_CH; ch++)
         exp.debug.ch_field[ch] = {1'b0, (en[ch] ? scrub_pkg::ST_DONE : scrub_pkg::ST_IDLE)};
      exp.debug.mark = scrub_pkg::STATUS_MARK;
      exp.debug.done = en;
      sel_ch = (sel < scrub_pkg::NUM_CH) ? int'(sel) : 0;
      addr   = en[sel_ch] ? LAST_BURST : 64'd0;
      check_value("status_word[31:4]", status_word[31:4], exp[31:4]);
      check_value("id0", id0, addr[31:0]);
      check_value("id1", id1, addr[63:32]);
   endtask

   task automatic run_round();
      logic [3:0] en;
      logic [2:0] sel;
      en = 4'($urandom_range(15, 1));
      for (int ch = 0; ch < scrub_pkg::NUM_CH; ch++)
         burst_count[ch] = 0;
      drive_ctl(1'b0, 3'd0, en);
      do
         @(negedge clk);
      while ((status_word[7:4] & en) != en);
      check_normal(en);
      for (int ch = 0; ch < scrub_pkg::NUM_CH; ch++)
         check_value($sformatf("burst count ch%0d", ch), burst_count[ch], en[ch] ? BURSTS : 0);
      repeat (3)
      begin
         sel = 3'($urandom_range(7, 0));
         drive_ctl(1'b1, sel, en);
         wait_outputs();
         check_debug(en, sel);
      end
      // Disabling all channels clears the done bits after decoder, scrubber and mux
      drive_ctl(1'b0, 3'd0, 4'h0);
      repeat (3) @(posedge clk);
      @(negedge clk);
      check_normal(4'h0);
   endtask

   task automatic test_flr();
      @(posedge clk);
      flr_assert <= 1'b1;
      @(negedge clk);
      check_value("flr_done", flr_done, 1'b0);
      @(posedge clk);
      flr_assert <= 1'b0;
      for (int c = 1; c < 6; c++)
      begin
         @(negedge clk);
         check_value("flr_done", flr_done, c == 2);
      end
      // Held request answers every other cycle
      @(posedge clk);
      flr_assert <= 1'b1;
      for (int c = 0; c < 8; c++)
      begin
         @(negedge clk);
         check_value("flr_done", flr_done, (c >= 2) && (c % 2 == 0));
      end
      @(posedge clk);
      flr_assert <= 1'b0;
      repeat (3) @(posedge clk);
   endtask

   // ------------------------------
   // Main sequence and watchdog
   // ------------------------------
   initial
   begin
      error_count    = 0;
      model_en       = '0;
      ready_check_on = 1'b0;
      rst_main_n     = 1'b0;
      flr_assert     = 1'b0;
      ctl_word       = '0;
      ddr_is_ready   = '0;
      mem_ack        = '0;
      for (int ch = 0; ch < scrub_pkg::NUM_CH; ch++)
         burst_count[ch] = 0;
      void'($urandom(76666));
      fork
         respond_channel(0);
         respond_channel(1);
         respond_channel(2);
         respond_channel(3);
         watch_channel(0);
         watch_channel(1);
         watch_channel(2);
         watch_channel(3);
         drive_ready_flags();
         watch_ready();
      join_none
      repeat (2) @(posedge clk);
      rst_main_n <= 1'b1;
      repeat (RESET_LATENCY + 3) @(posedge clk);
      ready_check_on = 1'b1;
      @(negedge clk);
      check_value("mem_req", mem_req, 4'h0);
      check_normal(4'h0);
      test_flr();
      repeat (NUM_ROUNDS) run_round();
      $display("Errors: %0d", error_count);
      if (error_count == 0)
         $display("TESTS PASSED");
      else
         $display("TESTS FAILED");
      $finish;
   end

   initial
   begin
      #(WATCHDOG_NS);
      $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
      $display("Errors: %0d", error_count);
      $display("TESTS FAILED");
      $finish;
   end

endmodule

//--- verification/tb_clock_gen.sv
/*
 * Free running testbench clock, 40 ns period, starting low.
 */

`timescale 1ns/1ns

module tb_clock_gen
(
   output logic clk
);

   localparam int HALF_PERIOD = 20;

   initial
   begin
      clk = 1'b0;
   end

   always #HALF_PERIOD clk = ~clk;

endmodule
